// ==== include/job_defines.svh ====
`ifndef JOB_DEFINES_SVH
`define JOB_DEFINES_SVH

`define JOB_DW      64
`define JOB_CW      6
`define JOB_FIFO_AW 6   // 64 entries.

// Control word fields.
`define JOB_OP_HI   5
`define JOB_OP_LO   3
`define JOB_TAG_HI  2
`define JOB_TAG_LO  0

// Opcodes. Values 5 to 7 are illegal.
`define JOB_OP_ADD  3'd0
`define JOB_OP_SUB  3'd1
`define JOB_OP_XOR  3'd2
`define JOB_OP_PASS 3'd3
`define JOB_OP_INC  3'd4

`endif

// ==== rtl/job_pkg.sv ====
`include "job_defines.svh"

package job_pkg;

    // Two 32-bit operands.
    typedef struct packed {
        logic [`JOB_DW/2-1:0] hi;
        logic [`JOB_DW/2-1:0] lo;
    } job_pair_t;

    // Same data word, seen as an operand pair or as one value.
    typedef union packed {
        job_pair_t           pair;
        logic [`JOB_DW-1:0]  word;
    } job_data_u;

endpackage

// ==== rtl/job_fifo_if.sv ====
`timescale 1ns/1ps
`include "job_defines.svh"

interface job_fifo_if;
    import job_pkg::*;

    // Write side.
    logic                  wr;
    job_data_u             w_data;
    logic [`JOB_CW-1:0]    w_ctrl;
    logic                  full;

    // Read side shows the queue head.
    logic                  rd;
    job_data_u             r_data;
    logic [`JOB_CW-1:0]    r_ctrl;
    logic                  empty;

    logic [`JOB_FIFO_AW:0] space; // Free entries.

    modport writer (output wr, w_data, w_ctrl, input full);

    modport reader (output rd, input r_data, r_ctrl, empty);

    modport fifo (
        input  wr, w_data, w_ctrl, rd,
        output full, r_data, r_ctrl, empty, space
    );

endinterface

// ==== rtl/job_fifo_buf.sv ====
`timescale 1ns/1ps

module job_fifo_buf #(
    parameter DWIDTH = 64,
    parameter CWIDTH = 6,
    parameter DEPTH  = 6
) (
    input logic     clk,
    input logic     reset,
    job_fifo_if.fifo q
);

    localparam logic [DEPTH:0] SLOTS = 2**DEPTH;

    logic [DWIDTH-1:0] darray [2**DEPTH];
    logic [CWIDTH-1:0] carray [2**DEPTH];

    logic [DEPTH-1:0] w_ptr, w_ptr_next, w_ptr_succ;
    logic [DEPTH-1:0] r_ptr, r_ptr_next, r_ptr_succ;
    logic             full_reg, full_next;
    logic             empty_reg, empty_next;
    logic [DEPTH:0]   space_reg, space_next;
    logic             wr_en, rd_en;

    assign wr_en = q.wr & ~full_reg;
    assign rd_en = q.rd & ~empty_reg;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            darray[w_ptr] <= q.w_data;
            carray[w_ptr] <= q.w_ctrl;
        end
    end

    // Show-ahead head entry.
    assign q.r_data = darray[r_ptr];
    assign q.r_ctrl = carray[r_ptr];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            w_ptr     <= '0;
            r_ptr     <= '0;
            full_reg  <= 1'b0;
            empty_reg <= 1'b1;
            space_reg <= SLOTS;
        end else begin
            w_ptr     <= w_ptr_next;
            r_ptr     <= r_ptr_next;
            full_reg  <= full_next;
            empty_reg <= empty_next;
            space_reg <= space_next;
        end
    end

    always_comb begin
        w_ptr_succ = w_ptr + 1'b1;
        r_ptr_succ = r_ptr + 1'b1;
        w_ptr_next = w_ptr;
        r_ptr_next = r_ptr;
        full_next  = full_reg;
        empty_next = empty_reg;
        case ({wr_en, rd_en})
            2'b01: begin
                r_ptr_next = r_ptr_succ;
                full_next  = 1'b0;
                empty_next = (r_ptr_succ == w_ptr);
            end
            2'b10: begin
                w_ptr_next = w_ptr_succ;
                empty_next = 1'b0;
                full_next  = (w_ptr_succ == r_ptr);
            end
            2'b11: begin
                // Occupancy and flags hold.
                w_ptr_next = w_ptr_succ;
                r_ptr_next = r_ptr_succ;
            end
            default: ;
        endcase
    end

    // Equal pointers mean all free unless full.
    always_comb begin
        if (full_next) begin
            space_next = '0;
        end else begin
            space_next = SLOTS - {1'b0, w_ptr_next - r_ptr_next};
        end
    end

    assign q.full  = full_reg;
    assign q.empty = empty_reg;
    assign q.space = space_reg;

endmodule

// ==== rtl/job_admit.sv ====
`timescale 1ns/1ps
`include "job_defines.svh"

module job_admit (
    input  logic               clk,
    input  logic               reset,
    input  logic               job_valid,
    input  logic [`JOB_DW-1:0] job_data,
    input  logic [`JOB_CW-1:0] job_ctrl,
    output logic [15:0]        bad_count,
    job_fifo_if.writer         q
);

    logic [2:0]         opcode;
    logic               legal;
    logic               wr_reg;
    logic [`JOB_DW-1:0] data_reg;
    logic [`JOB_CW-1:0] ctrl_reg;

    assign opcode = job_ctrl[`JOB_OP_HI:`JOB_OP_LO];
    assign legal  = (opcode <= `JOB_OP_INC);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_reg    <= 1'b0;
            bad_count <= '0;
        end else begin
            wr_reg <= job_valid & legal;
            if (job_valid && !legal && bad_count != 16'hffff) begin
                bad_count <= bad_count + 1'b1; // Saturates.
            end
        end
    end

    // Payload follows every strobe.
    always_ff @(posedge clk) begin
        if (job_valid) begin
            data_reg <= job_data;
            ctrl_reg <= job_ctrl;
        end
    end

    // FIFO drops the write itself when full.
    assign q.wr     = wr_reg;
    assign q.w_data = data_reg;
    assign q.w_ctrl = ctrl_reg;

endmodule

// ==== rtl/job_exec.sv ====
`timescale 1ns/1ps
`include "job_defines.svh"

module job_exec (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  exec_en,
    job_fifo_if.reader            q,
    output logic                  result_valid,
    output logic [`JOB_DW-1:0]    result,
    output logic [2:0]            result_tag
);
    import job_pkg::*;

    localparam int HW = `JOB_DW / 2;

    job_data_u          head;
    logic [2:0]         opcode;
    logic [2:0]         tag;
    logic [HW-1:0]      half_res;
    logic [`JOB_DW-1:0] result_next;
    logic               pop;

    assign head   = q.r_data;
    assign opcode = q.r_ctrl[`JOB_OP_HI:`JOB_OP_LO];
    assign tag    = q.r_ctrl[`JOB_TAG_HI:`JOB_TAG_LO];

    // One pop per cycle while enabled.
    assign pop  = exec_en & ~q.empty;
    assign q.rd = pop;

    // Operand pair ops.
    always_comb begin
        case (opcode)
            `JOB_OP_ADD: half_res = head.pair.hi + head.pair.lo;
            `JOB_OP_SUB: half_res = head.pair.hi - head.pair.lo;
            default:     half_res = head.pair.hi ^ head.pair.lo;
        endcase
    end

    always_comb begin
        case (opcode)
            `JOB_OP_ADD,
            `JOB_OP_SUB,
            `JOB_OP_XOR: begin
                result_next = {{HW{1'b0}}, half_res}; // Zero-extended.
            end
            `JOB_OP_PASS: begin
                result_next = head.word;
            end
            `JOB_OP_INC: begin
                result_next = head.word + 1'b1; // Wraps at 2^64.
            end
            default: begin
                // Admission never stores these.
                result_next = '0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            result     <= result_next;
            result_tag <= tag;
        end
    end

endmodule

// ==== rtl/job_top.sv ====
`timescale 1ns/1ps
`include "job_defines.svh"

module job_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   job_valid,
    input  logic [`JOB_DW-1:0]     job_data,
    input  logic [`JOB_CW-1:0]     job_ctrl,
    input  logic                   exec_en,
    output logic                   full,
    output logic                   empty,
    output logic [`JOB_FIFO_AW:0]  space,
    output logic [15:0]            bad_count,
    output logic                   result_valid,
    output logic [`JOB_DW-1:0]     result,
    output logic [2:0]             result_tag
);

    job_fifo_if q_if ();

    job_admit u_admit (
        .clk       (clk),
        .reset     (reset),
        .job_valid (job_valid),
        .job_data  (job_data),
        .job_ctrl  (job_ctrl),
        .bad_count (bad_count),
        .q         (q_if.writer)
    );

    job_fifo_buf #(
        .DWIDTH (`JOB_DW),
        .CWIDTH (`JOB_CW),
        .DEPTH  (`JOB_FIFO_AW)
    ) u_fifo (
        .clk   (clk),
        .reset (reset),
        .q     (q_if.fifo)
    );

    job_exec u_exec (
        .clk          (clk),
        .reset        (reset),
        .exec_en      (exec_en),
        .q            (q_if.reader),
        .result_valid (result_valid),
        .result       (result),
        .result_tag   (result_tag)
    );

    // Queue status for the producer.
    assign full  = q_if.full;
    assign empty = q_if.empty;
    assign space = q_if.space;

endmodule

// ==== tests/tb_job_top.sv ====
`timescale 1ns/1ps
`include "job_defines.svh"

module tb_job_top;

    localparam int SLOTS       = 2**`JOB_FIFO_AW;
    localparam int RAND_JOBS   = 200;
    localparam int MIX_CYCLES  = 800;
    localparam int CYCLE_LIMIT = 4000; // Tests run about 1300 cycles.

    logic                  clk;
    logic                  reset;
    logic                  job_valid;
    logic [`JOB_DW-1:0]    job_data;
    logic [`JOB_CW-1:0]    job_ctrl;
    logic                  exec_en;
    logic                  full;
    logic                  empty;
    logic [`JOB_FIFO_AW:0] space;
    logic [15:0]           bad_count;
    logic                  result_valid;
    logic [`JOB_DW-1:0]    result;
    logic [2:0]            result_tag;

    // Expected {result, tag} of each job in admission order.
    logic [`JOB_DW+2:0] exp_q [$];
    logic [`JOB_DW+2:0] exp_entry;

    integer seed = 65;
    int     errors;
    int     results_seen;
    int     stored_total; // Jobs predicted to reach the FIFO.
    int     bad_sent;
    int     cycles;
    int     rs_before;
    int     lat;
    int     pick;
    logic [2:0]         op;
    logic [2:0]         tag;
    logic [`JOB_DW-1:0] data;

    job_top UUT (
        .clk          (clk),
        .reset        (reset),
        .job_valid    (job_valid),
        .job_data     (job_data),
        .job_ctrl     (job_ctrl),
        .exec_en      (exec_en),
        .full         (full),
        .empty        (empty),
        .space        (space),
        .bad_count    (bad_count),
        .result_valid (result_valid),
        .result       (result),
        .result_tag   (result_tag)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Expected result by opcode.
    function automatic logic [63:0] job_ref(input logic [2:0] opc, input logic [63:0] word);
        logic [31:0] hi;
        logic [31:0] lo;
        logic [63:0] res;
        hi = word[63:32];
        lo = word[31:0];
        case (opc)
            `JOB_OP_ADD:  res = {32'd0, hi + lo};
            `JOB_OP_SUB:  res = {32'd0, hi - lo};
            `JOB_OP_XOR:  res = {32'd0, hi ^ lo};
            `JOB_OP_PASS: res = word;
            `JOB_OP_INC:  res = word + 64'd1;
            default:      res = '0;
        endcase
        return res;
    endfunction

    function automatic int rand_below(input int n);
        return {$random(seed)} % n;
    endfunction

    function automatic logic [63:0] rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic drive_job(input logic [2:0] opc, input logic [2:0] t,
                             input logic [63:0] word);
        job_valid = 1'b1;
        job_ctrl  = {opc, t};
        job_data  = word;
    endtask

    task automatic send_job(input logic [2:0] opc, input logic [2:0] t,
                            input logic [63:0] word);
        @(posedge clk);
        #1;
        drive_job(opc, t, word);
    endtask

    task automatic expect_job(input logic [2:0] opc, input logic [2:0] t,
                              input logic [63:0] word);
        exp_q.push_back({job_ref(opc, word), t});
        stored_total++;
    endtask

    task automatic send_legal(input logic [2:0] opc, input logic [2:0] t,
                              input logic [63:0] word);
        send_job(opc, t, word);
        expect_job(opc, t, word);
    endtask

    task automatic send_random_legal();
        send_legal(3'(rand_below(5)), 3'(rand_below(8)), rand_word());
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #1;
        job_valid = 1'b0;
    endtask

    task automatic set_exec(input logic en);
        @(posedge clk);
        #1;
        exec_en = en;
    endtask

    // Until every expected result is out and the queue is empty.
    task automatic wait_drain();
        @(negedge clk);
        while (exp_q.size() != 0 || !empty) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk); // Room for a stray extra result.
    endtask

    task automatic check_status(input logic exp_empty, input logic exp_full,
                                input int exp_space, input string what);
        if (empty !== exp_empty) begin
            errors++;
            $display("[FAIL] %0t: %s, empty %b, expected %b", $time, what, empty, exp_empty);
        end
        if (full !== exp_full) begin
            errors++;
            $display("[FAIL] %0t: %s, full %b, expected %b", $time, what, full, exp_full);
        end
        if (space !== 7'(exp_space)) begin
            errors++;
            $display("[FAIL] %0t: %s, space %0d, expected %0d", $time, what, space, exp_space);
        end
    endtask

    // Result checker.
    always @(negedge clk) begin
        if (!reset && result_valid) begin
            results_seen++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("Result %h with tag %0d came out at %0t when no job was waiting",
                         result, result_tag, $time);
            end else begin
                exp_entry = exp_q.pop_front();
                if (result !== exp_entry[`JOB_DW+2:3]) begin
                    errors++;
                    $display("[FAIL] %0t: result %h, expected %h",
                             $time, result, exp_entry[`JOB_DW+2:3]);
                end
                if (result_tag !== exp_entry[2:0]) begin
                    errors++;
                    $display("[FAIL] %0t: tag %0d, expected %0d",
                             $time, result_tag, exp_entry[2:0]);
                end
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, a drain or result never completed", CYCLE_LIMIT);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        reset        = 1'b1;
        job_valid    = 1'b0;
        job_data     = '0;
        job_ctrl     = '0;
        exec_en      = 1'b0;
        errors       = 0;
        results_seen = 0;
        stored_total = 0;
        bad_sent     = 0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        @(negedge clk);
        check_status(1'b1, 1'b0, SLOTS, "after reset");
        if (bad_count !== 16'd0) begin
            errors++;
            $display("[FAIL] %0t: bad_count %0d after reset", $time, bad_count);
        end
        if (result_valid !== 1'b0) begin
            errors++;
            $display("[FAIL] %0t: result_valid high after reset", $time);
        end

        // Latency through an empty queue.
        set_exec(1'b1);
        send_legal(`JOB_OP_PASS, 3'd5, 64'h0123_4567_89ab_cdef);
        idle_cycle();
        @(negedge clk);
        lat = 1;
        while (!result_valid && lat < 10) begin
            @(negedge clk);
            lat++;
        end
        if (lat != 3) begin
            errors++;
            $display("[FAIL] %0t: latency %0d cycles, expected 3", $time, lat);
        end

        // Corner values and random legal jobs.
        send_legal(`JOB_OP_ADD, 3'd1, 64'hffff_ffff_0000_0001);
        send_legal(`JOB_OP_SUB, 3'd2, 64'h0000_0001_0000_0002);
        send_legal(`JOB_OP_XOR, 3'd3, 64'ha5a5_a5a5_5a5a_5a5a);
        send_legal(`JOB_OP_INC, 3'd4, 64'hffff_ffff_ffff_ffff);
        send_legal(`JOB_OP_INC, 3'd6, 64'h0000_0000_ffff_ffff);
        for (int i = 0; i < RAND_JOBS; i++) begin
            send_random_legal();
        end
        idle_cycle();
        wait_drain();

        // Illegal opcodes.
        for (int i = 0; i < 12; i++) begin
            send_job(3'd5 + 3'(rand_below(3)), 3'(rand_below(8)), rand_word());
            bad_sent++;
        end
        idle_cycle();
        repeat (3) @(negedge clk);
        if (bad_count !== 16'(bad_sent)) begin
            errors++;
            $display("[FAIL] %0t: bad_count %0d, expected %0d", $time, bad_count, bad_sent);
        end
        check_status(1'b1, 1'b0, SLOTS, "after illegal jobs");

        // Fill with the executor stopped.
        set_exec(1'b0);
        rs_before = results_seen;
        for (int k = 0; k < SLOTS; k++) begin
            send_random_legal();
            @(negedge clk);
            // A job lands two edges after it is driven.
            lat = (k >= 1) ? k - 1 : 0;
            check_status(lat == 0, 1'b0, SLOTS - lat, "while filling");
        end
        idle_cycle();
        @(negedge clk);
        check_status(1'b0, 1'b0, 1, "one slot left");
        idle_cycle();
        @(negedge clk);
        check_status(1'b0, 1'b1, 0, "queue full");

        // Overflow jobs are dropped.
        for (int i = 0; i < 5; i++) begin
            send_job(3'(rand_below(5)), 3'(rand_below(8)), rand_word());
        end
        idle_cycle();
        repeat (2) @(negedge clk);
        check_status(1'b0, 1'b1, 0, "after overflow");
        if (results_seen != rs_before) begin
            errors++;
            $display("Results came out while the executor was disabled");
        end
        set_exec(1'b1);
        wait_drain();
        if (results_seen - rs_before != SLOTS) begin
            errors++;
            $display("[FAIL] %0t: %0d results after overflow, expected %0d",
                     $time, results_seen - rs_before, SLOTS);
        end
        check_status(1'b1, 1'b0, SLOTS, "after overflow drain");

        // Mixed traffic. Seen results lag pops and keep the estimate high.
        for (int i = 0; i < MIX_CYCLES; i++) begin
            @(posedge clk);
            #1;
            if (rand_below(32) == 0) begin
                exec_en = ~exec_en;
            end
            pick = rand_below(8);
            op   = 3'(rand_below(5));
            tag  = 3'(rand_below(8));
            data = rand_word();
            if (pick < 6 && !full && (stored_total - results_seen) < SLOTS) begin
                if (pick == 0) begin
                    op = 3'd5 + 3'(rand_below(3));
                    bad_sent++;
                end else begin
                    expect_job(op, tag, data);
                end
                drive_job(op, tag, data);
            end else begin
                job_valid = 1'b0;
            end
        end
        idle_cycle();
        exec_en = 1'b1;
        wait_drain();
        if (results_seen != stored_total) begin
            errors++;
            $display("[FAIL] %0t: %0d results, expected %0d", $time, results_seen, stored_total);
        end
        if (bad_count !== 16'(bad_sent)) begin
            errors++;
            $display("[FAIL] %0t: bad_count %0d, expected %0d", $time, bad_count, bad_sent);
        end
        check_status(1'b1, 1'b0, SLOTS, "end of run");

        $display("Errors: %0d, results checked: %0d, illegal jobs: %0d",
                 errors, results_seen, bad_sent);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+include
rtl/job_pkg.sv
rtl/job_fifo_if.sv
rtl/job_fifo_buf.sv
rtl/job_admit.sv
rtl/job_exec.sv
rtl/job_top.sv
tests/tb_job_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the job queue testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f filelist.f \
    --top-module tb_job_top \
    -o tb_job_top

./obj_dir/tb_job_top > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi

echo "Simulation passed"
exit 0
